//--- src.f
+incdir+verif
common/riscv_vm_pkg.sv
common/mmu_cfg_pkg.sv
hw/tlb/tlb.sv
hw/fetch_translate.sv
hw/data_translate.sv
hw/mmu_top.sv
verif/tb_mmu.sv

//--- run.sh
#!/bin/sh
# build and run the MMU testbench with Verilator, the simulation log decides the result
verilator --binary --timing --top-module tb_mmu -f src.f -o sim_mmu > build.log 2>&1 &&
  ./obj_dir/sim_mmu > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^=== PASS ===$" sim.log && exit 0 || exit 1

//--- verif/tb_mmu_tasks.svh
// expected value helpers, typed compare tasks, drive tasks and the
// directed MMU tests, included inside tb_mmu

// ------------------------------------------------
// stimulus and expected values
// ------------------------------------------------
function automatic vaddr_t random_vaddr(logic [8:0] vpn2);
  logic [31:0] r;
  r = $random(seed);
  // vpn2 keeps pages of different tests apart
  return {vpn2, r[29:0]};
endfunction

function automatic ppn_t random_ppn();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = $random(seed);
  lo = $random(seed);
  return {hi[11:0], lo};
endfunction

// size 0 is 4K, 1 is 2M, 2 is 1G
function automatic paddr_t page_paddr(ppn_t ppn, vaddr_t va, logic [1:0] size);
  case (size)
    2'd1:    return {ppn[43:9], va[20:0]};
    2'd2:    return {ppn[43:18], va[29:0]};
    default: return {ppn, va[11:0]};
  endcase
endfunction

function automatic exc_t fault_of(logic [3:0] cause, vaddr_t va);
  exc_t e;
  e       = '0;
  e.valid = 1'b1;
  e.cause = exc_cause_t'(cause);
  e.tval  = {{25{va[38]}}, va};
  return e;
endfunction

// leaf pte with v, r, x and a set
function automatic pte_t leaf_pte(ppn_t ppn, logic u, logic g, logic w, logic d);
  pte_t p;
  p     = '0;
  p.ppn = ppn;
  p.v   = 1'b1;
  p.r   = 1'b1;
  p.x   = 1'b1;
  p.a   = 1'b1;
  p.u   = u;
  p.g   = g;
  p.w   = w;
  p.d   = d;
  return p;
endfunction

// ------------------------------------------------
// compare tasks
// ------------------------------------------------
task automatic compare_paddr(string name, paddr_t got, paddr_t exp);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic compare_exc(string name, exc_t got, exc_t exp);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic compare_flag(string name, logic got, logic exp);
  check_cnt++;
  if (got !== exp) begin
    error_cnt++;
    $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// ------------------------------------------------
// drive tasks, entered and left on a falling edge
// ------------------------------------------------
task automatic fill(logic to_itlb, logic to_dtlb, vaddr_t va, logic [1:0] size, pte_t pte);
  tlb_update_t upd;
  upd       = '0;
  upd.valid = 1'b1;
  upd.vaddr = va;
  upd.asid  = 9'd1;
  upd.is_2m = (size == 2'd1);
  upd.is_1g = (size == 2'd2);
  upd.pte   = pte;
  if (to_itlb) itlb_update = upd;
  if (to_dtlb) dtlb_update = upd;
  @(negedge clk_i);
  itlb_update = '0;
  dtlb_update = '0;
endtask

task automatic flush_tlbs(asid_t asid, vaddr_t va);
  flush.valid = 1'b1;
  flush.asid  = asid;
  flush.vaddr = va;
  @(negedge clk_i);
  flush = '0;
endtask

// same cycle answer, paddr only looked at for a clean hit
task automatic fetch_check(vaddr_t va, logic exp_valid, logic exp_miss, paddr_t exp_pa,
                           exc_t exp_exc);
  fetch_req.req   = 1'b1;
  fetch_req.vaddr = va;
  #1;
  compare_flag("fetch_rsp_o.valid", fetch_rsp.valid, exp_valid);
  compare_flag("itlb_miss_o", itlb_miss, exp_miss);
  compare_exc("fetch_rsp_o.exc", fetch_rsp.exc, exp_exc);
  if (exp_valid && !exp_exc.valid) compare_paddr("fetch_rsp_o.paddr", fetch_rsp.paddr, exp_pa);
  @(negedge clk_i);
  fetch_req = '0;
endtask

// hit flags in the request cycle, response one cycle later and only once
task automatic data_check(vaddr_t va, logic is_store, logic misaligned, logic exp_hit,
                          logic exp_valid, paddr_t exp_pa, exc_t exp_exc);
  lsu_req.req        = 1'b1;
  lsu_req.vaddr      = va;
  lsu_req.is_store   = is_store;
  lsu_req.misaligned = misaligned;
  #1;
  compare_flag("lsu_dtlb_hit_o", lsu_dtlb_hit, exp_hit);
  compare_flag("dtlb_miss_o", dtlb_miss, csr.en_ld_st_translation && !exp_hit);
  @(negedge clk_i);
  lsu_req = '0;
  compare_flag("lsu_rsp_o.valid", lsu_rsp.valid, exp_valid);
  compare_exc("lsu_rsp_o.exc", lsu_rsp.exc, exp_exc);
  if (exp_valid && !exp_exc.valid) compare_paddr("lsu_rsp_o.paddr", lsu_rsp.paddr, exp_pa);
  @(negedge clk_i);
  compare_flag("lsu_rsp_o.valid", lsu_rsp.valid, 1'b0);
endtask

task automatic hit_probe(vaddr_t va, ppn_t ppn, logic exp_hit);
  data_check(va, 1'b0, 1'b0, exp_hit, exp_hit, page_paddr(ppn, va, 2'd0), '0);
endtask

// ------------------------------------------------
// directed tests
// ------------------------------------------------
task automatic reset_state();
  #1;
  compare_flag("fetch_rsp_o.valid", fetch_rsp.valid, 1'b0);
  compare_flag("lsu_rsp_o.valid", lsu_rsp.valid, 1'b0);
  compare_flag("itlb_miss_o", itlb_miss, 1'b0);
  compare_flag("dtlb_miss_o", dtlb_miss, 1'b0);
  @(negedge clk_i);
endtask

task automatic bare_mode_passthrough();
  vaddr_t va;
  va = random_vaddr(9'h0a5);
  fetch_check(va, 1'b1, 1'b0, {17'b0, va}, '0);
  data_check(va, 1'b0, 1'b0, 1'b1, 1'b1, {17'b0, va}, '0);
  data_check(va, 1'b1, 1'b0, 1'b1, 1'b1, {17'b0, va}, '0);
endtask

task automatic page_size_hits();
  vaddr_t va;
  ppn_t   ppn;
  csr.en_translation       = 1'b1;
  csr.en_ld_st_translation = 1'b1;
  for (int size = 0; size < 3; size++) begin
    va  = random_vaddr(9'(size + 1));
    ppn = random_ppn();
    fill(1'b1, 1'b1, va, 2'(size), leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1));
    fetch_check(va, 1'b1, 1'b0, page_paddr(ppn, va, 2'(size)), '0);
    data_check(va, 1'b0, 1'b0, 1'b1, 1'b1, page_paddr(ppn, va, 2'(size)), '0);
    data_check(va, 1'b1, 1'b0, 1'b1, 1'b1, page_paddr(ppn, va, 2'(size)), '0);
  end
endtask

task automatic lookup_misses();
  vaddr_t va;
  va = random_vaddr(9'h1f0);
  fetch_check(va, 1'b0, 1'b1, '0, '0);
  data_check(va, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
endtask

task automatic permission_faults();
  vaddr_t va;
  ppn_t   ppn;
  ppn = random_ppn();
  flush_tlbs('0, '0);
  // user page from S mode needs SUM
  va = random_vaddr(9'h004);
  fill(1'b0, 1'b1, va, 2'd0, leaf_pte(ppn, 1'b1, 1'b0, 1'b1, 1'b1));
  data_check(va, 1'b0, 1'b0, 1'b1, 1'b1, '0, fault_of(4'd13, va));
  csr.sum = 1'b1;
  data_check(va, 1'b0, 1'b0, 1'b1, 1'b1, page_paddr(ppn, va, 2'd0), '0);
  csr.sum = 1'b0;
  // store without w, then without d
  va = random_vaddr(9'h005);
  fill(1'b0, 1'b1, va, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b0, 1'b1));
  data_check(va, 1'b1, 1'b0, 1'b1, 1'b1, '0, fault_of(4'd15, va));
  va = random_vaddr(9'h006);
  fill(1'b0, 1'b1, va, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b0));
  data_check(va, 1'b1, 1'b0, 1'b1, 1'b1, '0, fault_of(4'd15, va));
  // fetch of a user page in S mode
  va = random_vaddr(9'h007);
  fill(1'b1, 1'b0, va, 2'd0, leaf_pte(ppn, 1'b1, 1'b0, 1'b1, 1'b1));
  fetch_check(va, 1'b1, 1'b0, '0, fault_of(4'd12, va));
  // a 39-bit vaddr always sign-extends, so the upper half is canonical
  va = random_vaddr(9'h1ff);
  fill(1'b1, 1'b0, va, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1));
  fetch_check(va, 1'b1, 1'b0, page_paddr(ppn, va, 2'd0), '0);
endtask

task automatic fence_flushes();
  vaddr_t va_a;
  vaddr_t va_b;
  vaddr_t va_g;
  ppn_t   ppn;
  ppn  = random_ppn();
  va_a = random_vaddr(9'h008);
  va_g = random_vaddr(9'h009);
  flush_tlbs('0, '0);
  fill(1'b0, 1'b1, va_a, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1));
  fill(1'b0, 1'b1, va_g, 2'd0, leaf_pte(ppn, 1'b0, 1'b1, 1'b1, 1'b1));
  // asid flush keeps the global page
  flush_tlbs(9'd1, '0);
  hit_probe(va_a, ppn, 1'b0);
  hit_probe(va_g, ppn, 1'b1);
  csr.asid = 9'd2;
  hit_probe(va_g, ppn, 1'b1);
  csr.asid = 9'd1;
  // address flush drops one page only
  va_a = random_vaddr(9'h00b);
  va_b = random_vaddr(9'h00c);
  fill(1'b0, 1'b1, va_a, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1));
  fill(1'b0, 1'b1, va_b, 2'd0, leaf_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1));
  flush_tlbs('0, va_a);
  hit_probe(va_a, ppn, 1'b0);
  hit_probe(va_b, ppn, 1'b1);
  flush_tlbs('0, '0);
  hit_probe(va_g, ppn, 1'b0);
  hit_probe(va_b, ppn, 1'b0);
endtask

task automatic misaligned_priority();
  vaddr_t va;
  ppn_t   ppn;
  ppn = random_ppn();
  va  = random_vaddr(9'h00d);
  // user page without w, load and store would both fault
  fill(1'b0, 1'b1, va, 2'd0, leaf_pte(ppn, 1'b1, 1'b0, 1'b0, 1'b1));
  data_check(va, 1'b0, 1'b1, 1'b1, 1'b1, '0, fault_of(4'd4, va));
  data_check(va, 1'b1, 1'b1, 1'b1, 1'b1, '0, fault_of(4'd6, va));
endtask

//--- verif/tb_mmu.sv
// MMU testbench top: clock, reset, DUT, watchdog and the directed test sequence
`timescale 1ns/100ps

module tb_mmu
  import riscv_vm_pkg::*;
  import mmu_cfg_pkg::*;
();

  localparam int unsigned clk_period  = 8;
  // about 80 cycles of directed tests plus reset
  localparam int unsigned test_cycles = 90;
  localparam int unsigned timeout_ns  = (test_cycles + 30) * clk_period;

  logic        clk_i;
  logic        rst_ni;
  fetch_req_t  fetch_req;
  lsu_req_t    lsu_req;
  csr_state_t  csr;
  tlb_flush_t  flush;
  tlb_update_t itlb_update;
  tlb_update_t dtlb_update;
  fetch_rsp_t  fetch_rsp;
  lsu_rsp_t    lsu_rsp;
  logic        lsu_dtlb_hit;
  logic        itlb_miss;
  logic        dtlb_miss;

  int unsigned error_cnt;
  int unsigned check_cnt;
  int          seed;

  mmu_top mmu_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req),
    .lsu_req_i      (lsu_req),
    .csr_i          (csr),
    .flush_i        (flush),
    .itlb_update_i  (itlb_update),
    .dtlb_update_i  (dtlb_update),
    .fetch_rsp_o    (fetch_rsp),
    .lsu_dtlb_hit_o (lsu_dtlb_hit),
    .lsu_rsp_o      (lsu_rsp),
    .itlb_miss_o    (itlb_miss),
    .dtlb_miss_o    (dtlb_miss)
  );

  `include "tb_mmu_tasks.svh"

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------
  initial begin : test_seq
    seed        = 32'h7d7e;
    error_cnt   = 0;
    check_cnt   = 0;
    rst_ni      = 1'b0;
    fetch_req   = '0;
    lsu_req     = '0;
    csr         = '0;
    flush       = '0;
    itlb_update = '0;
    dtlb_update = '0;
    // supervisor mode, asid 1 for all fills
    csr.priv_lvl       = priv_s;
    csr.ld_st_priv_lvl = priv_s;
    csr.asid           = 9'd1;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    bare_mode_passthrough();
    page_size_hits();
    lookup_misses();
    permission_faults();
    fence_flushes();
    misaligned_priority();
    @(negedge clk_i);
    $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // stops a hung sequence
  initial begin : watchdog
    #(timeout_ns);
    $display("timeout: test sequence still running after %0d ns", timeout_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- hw/mmu_top.sv
// Sv39 MMU top: instruction and data TLBs with their translators,
// TLB refill comes from outside through the update ports
`timescale 1ns/100ps

module mmu_top
  import mmu_cfg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_req_t  fetch_req_i,
  input  lsu_req_t    lsu_req_i,
  input  csr_state_t  csr_i,
  input  tlb_flush_t  flush_i,
  input  tlb_update_t itlb_update_i,
  input  tlb_update_t dtlb_update_i,
  output fetch_rsp_t  fetch_rsp_o,
  output logic        lsu_dtlb_hit_o,
  output lsu_rsp_t    lsu_rsp_o,
  output logic        itlb_miss_o,
  output logic        dtlb_miss_o
);

  tlb_lookup_t itlb_lookup;
  tlb_lookup_t dtlb_lookup;

  // ------------------------------------------------
  // TLBs, one flush feeds both
  // ------------------------------------------------
  tlb #(
    .num_entries (itlb_entries)
  ) i_itlb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lu_vaddr_i (fetch_req_i.vaddr),
    .lu_asid_i  (csr_i.asid),
    .update_i   (itlb_update_i),
    .flush_i    (flush_i),
    .lookup_o   (itlb_lookup)
  );

  tlb #(
    .num_entries (dtlb_entries)
  ) i_dtlb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lu_vaddr_i (lsu_req_i.vaddr),
    .lu_asid_i  (csr_i.asid),
    .update_i   (dtlb_update_i),
    .flush_i    (flush_i),
    .lookup_o   (dtlb_lookup)
  );

  // ------------------------------------------------
  // translators
  // ------------------------------------------------
  fetch_translate i_fetch_translate (
    .fetch_req_i (fetch_req_i),
    .csr_i       (csr_i),
    .lookup_i    (itlb_lookup),
    .fetch_rsp_o (fetch_rsp_o),
    .itlb_miss_o (itlb_miss_o)
  );

  // response lags the request by one cycle
  data_translate i_data_translate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .csr_i          (csr_i),
    .lookup_i       (dtlb_lookup),
    .lsu_dtlb_hit_o (lsu_dtlb_hit_o),
    .dtlb_miss_o    (dtlb_miss_o),
    .lsu_rsp_o      (lsu_rsp_o)
  );

endmodule

//--- hw/data_translate.sv
// Load/store side translation: one register stage, permission checks
// and misaligned / page fault selection
`timescale 1ns/100ps

module data_translate
  import riscv_vm_pkg::*;
  import mmu_cfg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  lsu_req_t    lsu_req_i,
  input  csr_state_t  csr_i,
  input  tlb_lookup_t lookup_i,
  output logic        lsu_dtlb_hit_o,
  output logic        dtlb_miss_o,
  output lsu_rsp_t    lsu_rsp_o
);

  lsu_req_t    lsu_req_q;
  tlb_lookup_t lookup_q;
  xlen_t       tval;
  logic        daccess_err;
  logic        store_err;

  // ------------------------------------------------
  // request cycle
  // ------------------------------------------------
  // always a hit in bare mode
  assign lsu_dtlb_hit_o = csr_i.en_ld_st_translation ? lookup_i.hit : 1'b1;
  assign dtlb_miss_o    = lsu_req_i.req && csr_i.en_ld_st_translation && !lookup_i.hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lsu_req_q <= '0;
    end else begin
      lsu_req_q <= lsu_req_i;
    end
  end

  // tlb result, only looked at with lsu_req_q.req
  always_ff @(posedge clk_i) begin
    lookup_q <= lookup_i;
  end

  // ------------------------------------------------
  // response cycle
  // ------------------------------------------------
  assign tval = sv39_tval(lsu_req_q.vaddr);

  // S mode needs SUM for user pages, U mode only reaches user pages
  assign daccess_err = ((csr_i.ld_st_priv_lvl == priv_s) && !csr_i.sum && lookup_q.pte.u)
                       || ((csr_i.ld_st_priv_lvl == priv_u) && !lookup_q.pte.u);

  // stores also need w and the dirty bit already set
  assign store_err = !lookup_q.pte.w || !lookup_q.pte.d || daccess_err;

  always_comb begin : lsu_rsp
    lsu_rsp_o       = '0;
    lsu_rsp_o.valid = lsu_req_q.req;
    lsu_rsp_o.paddr = paddr_t'(lsu_req_q.vaddr);
    if (lsu_req_q.req && lsu_req_q.misaligned) begin
      // misaligned wins over any translation result
      lsu_rsp_o.exc.valid = 1'b1;
      lsu_rsp_o.exc.cause = lsu_req_q.is_store ? st_addr_misaligned : ld_addr_misaligned;
      lsu_rsp_o.exc.tval  = tval;
    end else if (csr_i.en_ld_st_translation) begin
      lsu_rsp_o.valid = 1'b0;
      lsu_rsp_o.paddr = sv39_paddr(lookup_q.pte.ppn, lsu_req_q.vaddr,
                                   lookup_q.is_2m, lookup_q.is_1g);
      if (lsu_req_q.req && lookup_q.hit) begin
        lsu_rsp_o.valid = 1'b1;
        if (lsu_req_q.is_store && store_err) begin
          lsu_rsp_o.exc.valid = 1'b1;
          lsu_rsp_o.exc.cause = store_page_fault;
          lsu_rsp_o.exc.tval  = tval;
        end else if (!lsu_req_q.is_store && daccess_err) begin
          lsu_rsp_o.exc.valid = 1'b1;
          lsu_rsp_o.exc.cause = load_page_fault;
          lsu_rsp_o.exc.tval  = tval;
        end
      end
    end
  end

endmodule

//--- hw/fetch_translate.sv
// Fetch side translation: same cycle paddr composition and
// instruction page fault selection
`timescale 1ns/100ps

module fetch_translate
  import riscv_vm_pkg::*;
  import mmu_cfg_pkg::*;
(
  input  fetch_req_t  fetch_req_i,
  input  csr_state_t  csr_i,
  input  tlb_lookup_t lookup_i,
  output fetch_rsp_t  fetch_rsp_o,
  output logic        itlb_miss_o
);

  xlen_t tval;
  logic  iaccess_err;

  assign tval = sv39_tval(fetch_req_i.vaddr);

  // user page from S mode or supervisor page from U mode
  assign iaccess_err = ((csr_i.priv_lvl == priv_u) && !lookup_i.pte.u)
                       || ((csr_i.priv_lvl == priv_s) && lookup_i.pte.u);

  // perf counter pulse
  assign itlb_miss_o = fetch_req_i.req && csr_i.en_translation && !lookup_i.hit;

  always_comb begin : fetch_rsp
    fetch_rsp_o       = '0;
    // bare mode passes the vaddr straight through
    fetch_rsp_o.valid = fetch_req_i.req;
    fetch_rsp_o.paddr = paddr_t'(fetch_req_i.vaddr);
    if (csr_i.en_translation) begin
      fetch_rsp_o.valid = 1'b0;
      fetch_rsp_o.paddr = sv39_paddr(lookup_i.pte.ppn, fetch_req_i.vaddr,
                                     lookup_i.is_2m, lookup_i.is_1g);
      if (lookup_i.hit) begin
        fetch_rsp_o.valid = fetch_req_i.req;
        if (fetch_req_i.req && iaccess_err) begin
          fetch_rsp_o.exc.valid = 1'b1;
          fetch_rsp_o.exc.cause = instr_page_fault;
          fetch_rsp_o.exc.tval  = tval;
        end
      end
    end
  end

endmodule

//--- hw/tlb/tlb.sv
// Fully associative Sv39 TLB with ASID tags, 4K/2M/1G leaves,
// round-robin fill and fence style flush
`timescale 1ns/100ps

module tlb
  import riscv_vm_pkg::*;
  import mmu_cfg_pkg::*;
#(
  parameter int unsigned num_entries = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  vaddr_t      lu_vaddr_i,
  input  asid_t       lu_asid_i,
  input  tlb_update_t update_i,
  input  tlb_flush_t  flush_i,
  output tlb_lookup_t lookup_o
);

  localparam int unsigned idx_w = (num_entries > 1) ? $clog2(num_entries) : 1;

  typedef struct packed {
    asid_t                asid;
    logic [vpn_seg_w-1:0] vpn2;
    logic [vpn_seg_w-1:0] vpn1;
    logic [vpn_seg_w-1:0] vpn0;
    logic                 is_2m;
    logic                 is_1g;
    pte_t                 pte;
  } tlb_entry_t;

  logic [num_entries-1:0] valid_q, valid_d;
  tlb_entry_t             entry_q [num_entries];
  logic [idx_w-1:0]       victim_q;
  logic [idx_w-1:0]       fill_idx;
  logic [num_entries-1:0] lu_hit;
  logic [num_entries-1:0] flush_hit;

  // vpn compare, superpages ignore the lower levels
  function automatic logic vpn_match(tlb_entry_t e, vaddr_t va);
    logic l2, l1, l0;
    l2 = (e.vpn2 == va[page_off_w + 2*vpn_seg_w +: vpn_seg_w]);
    l1 = (e.vpn1 == va[page_off_w + vpn_seg_w +: vpn_seg_w]);
    l0 = (e.vpn0 == va[page_off_w +: vpn_seg_w]);
    return l2 && (e.is_1g || l1) && (e.is_1g || e.is_2m || l0);
  endfunction

  // ------------------------------------------------
  // lookup
  // ------------------------------------------------
  always_comb begin : lookup
    lookup_o = '0;
    for (int i = 0; i < num_entries; i++) begin
      // global entries match every asid
      lu_hit[i] = valid_q[i] && vpn_match(entry_q[i], lu_vaddr_i)
                  && (entry_q[i].pte.g || (entry_q[i].asid == lu_asid_i));
    end
    // lowest index wins, only one should match anyway
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (lu_hit[i]) begin
        lookup_o.hit   = 1'b1;
        lookup_o.is_2m = entry_q[i].is_2m;
        lookup_o.is_1g = entry_q[i].is_1g;
        lookup_o.pte   = entry_q[i].pte;
      end
    end
  end

  // ------------------------------------------------
  // flush, then fill
  // ------------------------------------------------
  always_comb begin : flush_fill
    valid_d = valid_q;
    for (int i = 0; i < num_entries; i++) begin
      if (flush_i.asid == '0 && flush_i.vaddr == '0) begin
        flush_hit[i] = 1'b1;
      end else if (flush_i.asid == '0) begin
        flush_hit[i] = vpn_match(entry_q[i], flush_i.vaddr);
      end else if (flush_i.vaddr == '0) begin
        flush_hit[i] = !entry_q[i].pte.g && (entry_q[i].asid == flush_i.asid);
      end else begin
        // address within one asid, globals survive
        flush_hit[i] = !entry_q[i].pte.g && (entry_q[i].asid == flush_i.asid)
                       && vpn_match(entry_q[i], flush_i.vaddr);
      end
      if (flush_i.valid && flush_hit[i]) begin
        valid_d[i] = 1'b0;
      end
    end
    // first free slot after the flush, else the victim pointer
    fill_idx = victim_q;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (!valid_d[i]) begin
        fill_idx = idx_w'(i);
      end
    end
    if (update_i.valid) begin
      valid_d[fill_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else begin
      valid_q <= valid_d;
      // victim pointer moves on every fill
      if (update_i.valid) begin
        victim_q <= (victim_q == idx_w'(num_entries - 1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  // entry payload, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      entry_q[fill_idx].asid  <= update_i.asid;
      entry_q[fill_idx].vpn2  <= update_i.vaddr[page_off_w + 2*vpn_seg_w +: vpn_seg_w];
      entry_q[fill_idx].vpn1  <= update_i.vaddr[page_off_w + vpn_seg_w +: vpn_seg_w];
      entry_q[fill_idx].vpn0  <= update_i.vaddr[page_off_w +: vpn_seg_w];
      entry_q[fill_idx].is_2m <= update_i.is_2m;
      entry_q[fill_idx].is_1g <= update_i.is_1g;
      entry_q[fill_idx].pte   <= update_i.pte;
    end
  end

endmodule

//--- common/mmu_cfg_pkg.sv
// MMU implementation sizes and the request, response, CSR, TLB update,
// flush and lookup structs
package mmu_cfg_pkg;
  import riscv_vm_pkg::*;

  localparam int unsigned asid_w       = 9;
  localparam int unsigned itlb_entries = 4;
  localparam int unsigned dtlb_entries = 4;

  typedef logic [asid_w-1:0] asid_t;

  typedef struct packed {
    logic       valid;
    exc_cause_t cause;
    xlen_t      tval;
  } exc_t;

  // ------------------------------------------------
  // fetch and load/store ports
  // ------------------------------------------------
  typedef struct packed {
    logic   req;
    vaddr_t vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic   valid;
    paddr_t paddr;
    exc_t   exc;
  } fetch_rsp_t;

  // misaligned is flagged by the LSU alongside the request
  typedef struct packed {
    logic   req;
    vaddr_t vaddr;
    logic   is_store;
    logic   misaligned;
  } lsu_req_t;

  typedef struct packed {
    logic   valid;
    paddr_t paddr;
    exc_t   exc;
  } lsu_rsp_t;

  // translation related CSR state
  typedef struct packed {
    priv_lvl_t priv_lvl;
    priv_lvl_t ld_st_priv_lvl;
    logic      sum;
    logic      en_translation;
    logic      en_ld_st_translation;
    asid_t     asid;
  } csr_state_t;

  // ------------------------------------------------
  // TLB side
  // ------------------------------------------------
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
    asid_t  asid;
    logic   is_2m;
    logic   is_1g;
    pte_t   pte;
  } tlb_update_t;

  // fence semantics, zero asid or zero vaddr widen the flush
  typedef struct packed {
    logic   valid;
    asid_t  asid;
    vaddr_t vaddr;
  } tlb_flush_t;

  typedef struct packed {
    logic hit;
    logic is_2m;
    logic is_1g;
    pte_t pte;
  } tlb_lookup_t;

endpackage

//--- common/riscv_vm_pkg.sv
// Sv39 architectural definitions: address widths, PTE layout, privilege levels,
// exception causes and the address composition helpers
package riscv_vm_pkg;

  // address and field widths
  localparam int unsigned vlen       = 39;
  localparam int unsigned plen       = 56;
  localparam int unsigned ppn_w      = 44;
  localparam int unsigned xlen       = 64;
  localparam int unsigned page_off_w = 12;
  localparam int unsigned vpn_seg_w  = 9;

  typedef logic [vlen-1:0]  vaddr_t;
  typedef logic [plen-1:0]  paddr_t;
  typedef logic [ppn_w-1:0] ppn_t;
  typedef logic [xlen-1:0]  xlen_t;

  // leaf PTE, msb first as in memory
  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_s = 2'b01,
    priv_m = 2'b11
  } priv_lvl_t;

  // mcause encodings of the exceptions this MMU can raise
  typedef enum logic [3:0] {
    instr_access_fault = 4'd1,
    ld_addr_misaligned = 4'd4,
    st_addr_misaligned = 4'd6,
    instr_page_fault   = 4'd12,
    load_page_fault    = 4'd13,
    store_page_fault   = 4'd15
  } exc_cause_t;

  // physical address from a leaf PTE, superpages pass the low VPN levels through
  function automatic paddr_t sv39_paddr(ppn_t ppn, vaddr_t va, logic is_2m, logic is_1g);
    paddr_t pa;
    pa = {ppn, va[page_off_w-1:0]};
    if (is_2m) begin
      pa[page_off_w +: vpn_seg_w] = va[page_off_w +: vpn_seg_w];
    end
    if (is_1g) begin
      pa[page_off_w +: 2*vpn_seg_w] = va[page_off_w +: 2*vpn_seg_w];
    end
    return pa;
  endfunction

  // tval carries the virtual address sign-extended to xlen
  function automatic xlen_t sv39_tval(vaddr_t va);
    return {{(xlen - vlen){va[vlen-1]}}, va};
  endfunction

endpackage
